// ==== Makefile ====
# Verilator lint and simulation of the serial slave testbench

TOP   := ser_slave_tb
BUILD := obj_dir
LOG   := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

$(BUILD)/V$(TOP): filelist.f verilog/*.sv tb/*.sv
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) \
		--Mdir $(BUILD) -o V$(TOP)

sim: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== filelist.f ====
verilog/ser_slave_pkg.sv
verilog/ser_frame_rx.sv
verilog/ser_word_mem.sv
verilog/ser_read_tx.sv
verilog/ser_slave_top.sv
tb/ser_slave_properties.sv
tb/ser_slave_tb.sv

// ==== tb/ser_slave_properties.sv ====
// ======================================================================
// handshake assertions of the serial slave, bound to the top level
// checks the quiet rD line, ready after reset and bit hold under stall
// ======================================================================
`timescale 1ns/1ps

module ser_slave_properties (
    input logic clk,
    input logic rstN,
    input logic valid,
    input logic ready,
    input logic rD,
    input logic bit_valid
);

    // no read bit on offer means ready low and a quiet data line
    property rd_quiet_when_not_ready;
        @(posedge clk) disable iff (!rstN) !ready |-> !rD;
    endproperty

    // slave accepts a frame from the first cycle out of reset
    property ready_after_reset;
        @(posedge clk) $rose(rstN) |-> ready;
    endproperty

    // master stall keeps the presented bit in place
    property bit_held_on_stall;
        @(posedge clk) disable iff (!rstN) (bit_valid && !valid) |=> (rD == $past(rD));
    endproperty

    assert property (rd_quiet_when_not_ready)
        else $error("rD is high while ready is low");

    assert property (ready_after_reset)
        else $error("ready is low in the first cycle after reset");

    assert property (bit_held_on_stall)
        else $error("rD changed while the master held valid low");

endmodule

bind ser_slave_top ser_slave_properties u_props (
    .clk       (clk),
    .rstN      (rstN),
    .valid     (valid),
    .ready     (ready),
    .rD        (rD),
    .bit_valid (bit_valid)
);

// ==== tb/ser_slave_tb.sv ====
// ======================================================================
// testbench of the serial bus slave: applies a table of write and read
// frames, keeps a reference memory and compares every word read back
// ======================================================================
`timescale 1ns/1ps

module ser_slave_tb;
    import ser_slave_pkg::*;

    localparam slave_id_t MY_ID    = 2'd1;
    localparam int        WAIT_MAX = 200;
    localparam int        N_TXN    = 11;

    typedef struct packed {
        logic       wr;
        logic       burst;
        slave_id_t  id;
        logic [2:0] code;
        addr_t      addr;
        logic [2:0] words;
        logic       gaps;
    } txn_t;

    logic   clk;
    logic   rstN;
    logic   control;
    logic   wD;
    logic   valid;
    logic   last;
    logic   rD;
    logic   ready;

    word_t  ref_mem [2**ADDR_WIDTH];
    txn_t   txn_table [N_TXN];
    integer seed;
    int     errors;
    int     entry_errors;
    int     failed_entries;
    bit     timed_out;

    ser_slave_top #(
        .SLAVE_ID  (MY_ID),
        .MEM_DEPTH (256)
    ) dut (
        .clk     (clk),
        .rstN    (rstN),
        .control (control),
        .wD      (wD),
        .valid   (valid),
        .last    (last),
        .rD      (rD),
        .ready   (ready)
    );

    always #4 clk = ~clk;

    task automatic check(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            errors++;
            entry_errors++;
        end
    endtask

    task automatic note_timeout(input string what);
        $display("timeout: %s within %0d cycles, at %0t ns", what, WAIT_MAX, $time);
        timed_out = 1'b1;
        errors++;
        entry_errors++;
    endtask

    task automatic fill_table();
        // wr, burst, id, start code, address, words, valid gaps
        txn_table[0]  = '{1'b1, 1'b0, 2'd1, 3'b111, 8'h10, 3'd1, 1'b0};
        txn_table[1]  = '{1'b0, 1'b0, 2'd1, 3'b111, 8'h10, 3'd1, 1'b0};
        txn_table[2]  = '{1'b1, 1'b1, 2'd1, 3'b111, 8'h20, 3'd4, 1'b0};
        txn_table[3]  = '{1'b0, 1'b1, 2'd1, 3'b111, 8'h20, 3'd4, 1'b0};
        // wrong id, then wrong start code
        txn_table[4]  = '{1'b1, 1'b0, 2'd2, 3'b111, 8'h10, 3'd1, 1'b0};
        txn_table[5]  = '{1'b1, 1'b1, 2'd1, 3'b101, 8'h20, 3'd2, 1'b0};
        txn_table[6]  = '{1'b0, 1'b0, 2'd1, 3'b111, 8'h10, 3'd1, 1'b0};
        txn_table[7]  = '{1'b0, 1'b1, 2'd1, 3'b111, 8'h20, 3'd4, 1'b0};
        txn_table[8]  = '{1'b1, 1'b1, 2'd1, 3'b111, 8'h40, 3'd3, 1'b1};
        txn_table[9]  = '{1'b0, 1'b1, 2'd1, 3'b111, 8'h20, 3'd4, 1'b1};
        txn_table[10] = '{1'b0, 1'b1, 2'd1, 3'b111, 8'h40, 3'd3, 1'b1};
    endtask

    // frame goes out msb first, one bit per clock
    task automatic send_frame(input txn_t t);
        frame_t f;
        f = {t.code, t.id, t.wr, t.burst, t.addr};
        for (int i = FRAME_BITS - 1; i >= 0; i--) begin
            @(posedge clk);
            control <= f[i];
            valid   <= 1'b0;
            last    <= 1'b0;
        end
    endtask

    // one bit handshake; ready_wait counts cycles until ready was first high
    task automatic xfer_bit(input logic wbit, input logic lst, input logic gaps,
                            output logic rbit, output int ready_wait);
        int   n;
        logic v;
        bit   done;
        n = 0;
        done = 1'b0;
        ready_wait = 0;
        rbit = 1'b0;
        while (!done && !timed_out) begin
            @(posedge clk);
            v = gaps ? (($random(seed) & 3) != 0) : 1'b1;
            control <= 1'b0;
            valid   <= v;
            wD      <= wbit;
            last    <= lst;
            @(negedge clk);
            n++;
            if (ready && ready_wait == 0) begin
                ready_wait = n;
            end
            if (ready && v) begin
                rbit = rD;
                done = 1'b1;
            end else if (n >= WAIT_MAX) begin
                note_timeout("no bit handshake");
            end
        end
    endtask

    task automatic xfer_word(input word_t wdata, input logic lst, input logic gaps,
                             output word_t rdata, output int first_wait);
        logic rbit;
        int   w;
        rdata = '0;
        first_wait = 0;
        for (int b = DATA_WIDTH - 1; b >= 0; b--) begin
            xfer_bit(wdata[b], lst && (b == 0), gaps, rbit, w);
            rdata[b] = rbit;
            if (b == DATA_WIDTH - 1) begin
                first_wait = w;
            end
        end
    endtask

    // bus quiet, then wait for the slave to be back in idle
    task automatic idle_bus();
        int n;
        n = 0;
        repeat (2) begin
            @(posedge clk);
            control <= 1'b0;
            valid   <= 1'b0;
            wD      <= 1'b0;
            last    <= 1'b0;
        end
        @(negedge clk);
        while (!ready && !timed_out) begin
            n++;
            if (n >= WAIT_MAX) begin
                note_timeout("ready did not return after the transaction");
            end else begin
                @(negedge clk);
            end
        end
        check(word_t'(rD), word_t'(0), "rD while idle");
    endtask

    task automatic run_txn(input txn_t t);
        word_t wdata;
        word_t rdata;
        int    first_wait;
        bit    match;
        addr_t a;
        match = (t.code == START_CODE) && (t.id == MY_ID);
        a = t.addr;
        send_frame(t);
        for (int k = 0; k < int'(t.words); k++) begin
            wdata = $random(seed);
            xfer_word(wdata, t.burst && (k == int'(t.words) - 1), t.gaps, rdata, first_wait);
            if (t.wr && match) begin
                ref_mem[a] = wdata;
            end else if (!t.wr && !timed_out) begin
                check(rdata, ref_mem[a], $sformatf("read word at address %h", a));
                if (k == 0) begin
                    check(word_t'(first_wait), word_t'(3), "first read bit latency");
                end
            end
            a = a + 1'b1;
        end
        idle_bus();
    endtask

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        control = 1'b0;
        wD = 1'b0;
        valid = 1'b0;
        last = 1'b0;
        seed = 32'hf1da_a49c;
        errors = 0;
        entry_errors = 0;
        failed_entries = 0;
        timed_out = 1'b0;
        fill_table();

        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        check(word_t'(ready), word_t'(1), "ready after reset");
        check(word_t'(rD), word_t'(0), "rD after reset");
        $display("reset: %s", (entry_errors == 0) ? "ok" : "errors");

        for (int i = 0; i < N_TXN; i++) begin
            entry_errors = 0;
            run_txn(txn_table[i]);
            if (entry_errors != 0) begin
                failed_entries++;
            end
            $display("entry %0d: %s %s addr %h words %0d: %s", i,
                     txn_table[i].wr ? "write" : "read",
                     txn_table[i].burst ? "burst" : "single",
                     txn_table[i].addr, txn_table[i].words,
                     (entry_errors == 0) ? "ok" : "errors");
            if (timed_out) begin
                break;
            end
        end

        $display("entries %0d, failed entries %0d, errors %0d", N_TXN, failed_entries, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/ser_frame_rx.sv ====
// ======================================================================
// frame receiver of the serial slave: shifts in the control frame,
// checks start code and id, then deserializes write words or walks
// the read addresses; also drives ready towards the master
// ======================================================================
`timescale 1ns/1ps

module ser_frame_rx #(
    parameter ser_slave_pkg::slave_id_t SLAVE_ID = 1
) (
    input  logic                 clk,
    input  logic                 rstN,
    // serial bus from the master
    input  logic                 control,
    input  logic                 wD,
    input  logic                 valid,
    input  logic                 last,
    output logic                 ready,
    // status from the read serializer
    input  logic                 bit_valid,
    input  logic                 word_done,
    input  logic                 burst_last,
    // memory write port
    output logic                 wr_en,
    output ser_slave_pkg::addr_t wr_addr,
    output ser_slave_pkg::word_t wr_data,
    // memory read request and serializer load
    output logic                 rd_en,
    output ser_slave_pkg::addr_t rd_addr,
    output logic                 load
);
    import ser_slave_pkg::*;

    rx_state_e                  state;

    // frame bits 1 .. FRAME_BITS-1, the final bit comes straight from control
    logic [FRAME_BITS-2:0]      frame_sr;
    logic [FRAME_CNT_WIDTH-1:0] frame_cnt;
    frame_t                     rx_frame;
    logic                       frame_ok;

    addr_t                      addr;
    logic                       burst_q;

    // write deserializer
    word_t                      wr_sr;
    logic [BIT_CNT_WIDTH-1:0]   bit_cnt;
    logic                       last_seen;
    logic                       bit_accept;
    logic                       word_end;

    // full frame is valid only in the decode cycle
    assign rx_frame = {frame_sr, control};
    assign frame_ok = (rx_frame[START_MSB:START_LSB] == START_CODE) &&
                      (rx_frame[ID_MSB:ID_LSB] == SLAVE_ID);

    assign bit_accept = (state == write) && valid;
    assign word_end   = bit_accept && (bit_cnt == BIT_CNT_WIDTH'(DATA_WIDTH - 1));

    // memory sees the stored address; addr moves on after each access
    assign wr_addr = addr;
    assign wr_data = wr_sr;
    assign rd_addr = addr;

    // ready follows the serializer while a read is running
    assign ready = (state == read_wait || state == read) ? bit_valid : 1'b1;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= idle;
            frame_cnt <= '0;
            addr      <= '0;
            burst_q   <= 1'b0;
            bit_cnt   <= '0;
            last_seen <= 1'b0;
            wr_en     <= 1'b0;
            rd_en     <= 1'b0;
            load      <= 1'b0;
        end else begin
            // word is written one cycle after its final bit
            wr_en <= word_end;
            rd_en <= 1'b0;
            // load lines up with the memory read data
            load  <= rd_en;

            if (wr_en) begin
                addr <= addr + 1'b1;
            end

            case (state)
                idle: begin
                    if (control) begin
                        frame_cnt <= FRAME_CNT_WIDTH'(1);
                        state     <= frame;
                    end
                end

                frame: begin
                    frame_cnt <= frame_cnt + 1'b1;
                    if (frame_cnt == FRAME_CNT_WIDTH'(FRAME_BITS - 2)) begin
                        state <= decode;
                    end
                end

                decode: begin
                    if (!frame_ok) begin
                        // not for us, drop the frame
                        state <= idle;
                    end else begin
                        addr      <= rx_frame[ADDR_WIDTH-1:0];
                        burst_q   <= rx_frame[BURST_BIT];
                        bit_cnt   <= '0;
                        last_seen <= 1'b0;
                        if (rx_frame[RW_BIT]) begin
                            state <= write;
                        end else begin
                            rd_en <= 1'b1;
                            state <= read_wait;
                        end
                    end
                end

                write: begin
                    if (word_end) begin
                        bit_cnt   <= '0;
                        last_seen <= 1'b0;
                        // a burst stops after the word that carried last
                        if (!burst_q || last_seen || last) begin
                            state <= idle;
                        end
                    end else if (bit_accept) begin
                        bit_cnt   <= bit_cnt + 1'b1;
                        last_seen <= last_seen | last;
                    end
                end

                read_wait: begin
                    if (load) begin
                        state <= read;
                    end
                end

                read: begin
                    if (word_done) begin
                        if (burst_q && !burst_last) begin
                            addr  <= addr + 1'b1;
                            rd_en <= 1'b1;
                            state <= read_wait;
                        end else begin
                            state <= idle;
                        end
                    end
                end

                default: state <= idle;
            endcase
        end
    end

    // shift registers hold payload only
    always_ff @(posedge clk) begin
        if (state == idle || state == frame) begin
            frame_sr <= {frame_sr[FRAME_BITS-3:0], control};
        end
        if (bit_accept) begin
            // msb first
            wr_sr <= {wr_sr[DATA_WIDTH-2:0], wD};
        end
    end

endmodule

// ==== verilog/ser_read_tx.sv ====
// ======================================================================
// read serializer: takes a memory word on load and shifts it out on
// rD, msb first, one bit per cycle with valid; reports the end of the
// word and whether the master flagged last during it
// ======================================================================
`timescale 1ns/1ps

module ser_read_tx (
    input  logic                 clk,
    input  logic                 rstN,
    // word from the memory
    input  logic                 load,
    input  ser_slave_pkg::word_t rd_data,
    // master handshake
    input  logic                 valid,
    input  logic                 last,
    // serial data and status
    output logic                 rD,
    output logic                 bit_valid,
    output logic                 word_done,
    output logic                 burst_last
);
    import ser_slave_pkg::*;

    word_t                    shift_q;
    logic [BIT_CNT_WIDTH-1:0] bit_cnt;
    logic                     last_seen;
    logic                     consume;
    logic                     final_bit;

    // a bit leaves on every cycle the master takes it
    assign consume   = bit_valid && valid;
    assign final_bit = (bit_cnt == BIT_CNT_WIDTH'(DATA_WIDTH - 1));

    // keep rD quiet when no bit is on offer
    assign rD = bit_valid ? shift_q[DATA_WIDTH-1] : 1'b0;

    assign burst_last = last_seen;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bit_cnt   <= '0;
            bit_valid <= 1'b0;
            word_done <= 1'b0;
            last_seen <= 1'b0;
        end else begin
            word_done <= 1'b0;
            if (load) begin
                bit_cnt   <= '0;
                bit_valid <= 1'b1;
                last_seen <= 1'b0;
            end else if (consume) begin
                last_seen <= last_seen | last;
                if (final_bit) begin
                    // word finished, wait for the next load
                    bit_valid <= 1'b0;
                    word_done <= 1'b1;
                    bit_cnt   <= '0;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // data path, bit stays put while valid is low
    always_ff @(posedge clk) begin
        if (load) begin
            shift_q <= rd_data;
        end else if (consume) begin
            shift_q <= {shift_q[DATA_WIDTH-2:0], 1'b0};
        end
    end

endmodule

// ==== verilog/ser_slave_pkg.sv ====
// ======================================================================
// shared widths, frame layout and types of the serial bus slave
// imported by every RTL block and by the testbench
// ======================================================================
package ser_slave_pkg;

    // word and address sizes
    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 8;
    localparam int ID_WIDTH   = 2;

    // control frame: start | id | r/w | burst | address
    localparam logic [2:0] START_CODE = 3'b111;
    localparam int         FRAME_BITS = 3 + ID_WIDTH + 2 + ADDR_WIDTH;

    // bit positions inside a received frame, msb arrives first
    localparam int START_MSB = FRAME_BITS - 1;
    localparam int START_LSB = FRAME_BITS - 3;
    localparam int ID_MSB    = START_LSB - 1;
    localparam int ID_LSB    = START_LSB - ID_WIDTH;
    localparam int RW_BIT    = ID_LSB - 1;
    localparam int BURST_BIT = RW_BIT - 1;

    // counters for word bits and frame bits
    localparam int BIT_CNT_WIDTH   = $clog2(DATA_WIDTH);
    localparam int FRAME_CNT_WIDTH = $clog2(FRAME_BITS);

    typedef logic [DATA_WIDTH-1:0] word_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [ID_WIDTH-1:0]   slave_id_t;
    typedef logic [FRAME_BITS-1:0] frame_t;

    // receiver states
    typedef enum logic [2:0] {
        idle,
        frame,
        decode,
        write,
        read_wait,
        read
    } rx_state_e;

endpackage

// ==== verilog/ser_slave_top.sv ====
// ======================================================================
// top level of the serial bus slave
// ties the frame receiver, the word memory and the read serializer
// to the serial bus; SLAVE_ID and MEM_DEPTH are set here
// ======================================================================
`timescale 1ns/1ps

module ser_slave_top #(
    parameter ser_slave_pkg::slave_id_t SLAVE_ID  = 1,
    parameter int                       MEM_DEPTH = 256
) (
    input  logic clk,
    input  logic rstN,
    // serial bus, master side
    input  logic control,
    input  logic wD,
    input  logic valid,
    input  logic last,
    output logic rD,
    output logic ready
);
    import ser_slave_pkg::*;

    // memory ports
    logic  wr_en;
    addr_t wr_addr;
    word_t wr_data;
    logic  rd_en;
    addr_t rd_addr;
    word_t rd_data;

    // serializer control and status
    logic  load;
    logic  bit_valid;
    logic  word_done;
    logic  burst_last;

    ser_frame_rx #(
        .SLAVE_ID   (SLAVE_ID)
    ) u_frame_rx (
        .clk        (clk),
        .rstN       (rstN),
        .control    (control),
        .wD         (wD),
        .valid      (valid),
        .last       (last),
        .ready      (ready),
        .bit_valid  (bit_valid),
        .word_done  (word_done),
        .burst_last (burst_last),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .load       (load)
    );

    ser_word_mem #(
        .MEM_DEPTH  (MEM_DEPTH)
    ) u_word_mem (
        .clk        (clk),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    ser_read_tx u_read_tx (
        .clk        (clk),
        .rstN       (rstN),
        .load       (load),
        .rd_data    (rd_data),
        .valid      (valid),
        .last       (last),
        .rD         (rD),
        .bit_valid  (bit_valid),
        .word_done  (word_done),
        .burst_last (burst_last)
    );

endmodule

// ==== verilog/ser_word_mem.sv ====
// ======================================================================
// word memory behind the serial slave
// one synchronous write port, one read port with registered data
// ======================================================================
`timescale 1ns/1ps

module ser_word_mem #(
    parameter int MEM_DEPTH = 256
) (
    input  logic                 clk,
    // write port
    input  logic                 wr_en,
    input  ser_slave_pkg::addr_t wr_addr,
    input  ser_slave_pkg::word_t wr_data,
    // read port, data one cycle after rd_en
    input  logic                 rd_en,
    input  ser_slave_pkg::addr_t rd_addr,
    output ser_slave_pkg::word_t rd_data
);
    import ser_slave_pkg::*;

    word_t mem [MEM_DEPTH];

    // write lands at the clock edge
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // rd_data holds its value until the next request
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule
